// ==== Makefile ====
# Verilator simulation of tiny45_core; every variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_tiny45_core
FILELIST  ?= tiny45_core.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tiny45_core_model.svh ====
// reference model for the execute slice; expects RV32E register fields and only the supported opcode classes
`ifndef TINY45_CORE_MODEL_SVH
`define TINY45_CORE_MODEL_SVH

logic [31:0] model_regs [`TINY45_NUM_REGS];

function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] x, input logic [31:0] y);
    case (f3)
        3'd0: ref_alu = alt ? x - y : x + y;
        3'd1: ref_alu = x << y[4:0];
        3'd2: ref_alu = {31'b0, $signed(x) < $signed(y)};
        3'd3: ref_alu = {31'b0, x < y};
        3'd4: ref_alu = x ^ y;
        3'd5: ref_alu = alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
        3'd6: ref_alu = x | y;
        default: ref_alu = x & y;
    endcase
endfunction

// expected result of one strobe, then the register write it implies
task automatic model_apply(input logic [31:0] w, input logic [31:0] p,
                           output tiny45_pkg::exec_result_t e);
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        take;
    f3    = w[14:12];
    a     = model_regs[w[18:15]];
    b     = model_regs[w[23:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    e         = '0;
    e.wb_rd   = w[10:7];
    e.next_pc = (w[1:0] == 2'b11) ? p + 32'd4 : p + 32'd2;  // short words only step by 2
    if (w[1:0] == 2'b11) begin
        case (w[6:2])
            5'b01100: e.wb_data = ref_alu(f3, w[30], a, b);
            5'b00100: e.wb_data = ref_alu(f3, w[30] && (f3 == 3'd5), a, imm_i);
            5'b01101: e.wb_data = imm_u;
            5'b00101: e.wb_data = p + imm_u;
            5'b11011: begin
                e.wb_data = p + 32'd4;
                e.next_pc = p + imm_j;
            end
            5'b11001: begin
                e.wb_data = p + 32'd4;
                e.next_pc = (a + imm_i) & ~32'd1;
            end
            5'b11000: begin
                case (f3[2:1])
                    2'b00: take = (a == b);
                    2'b10: take = ($signed(a) < $signed(b));
                    default: take = (a < b);
                endcase
                e.branch_taken = take ^ f3[0];  // odd funct3 negates the test
                if (e.branch_taken) begin
                    e.next_pc = p + imm_b;
                end
            end
            5'b00000, 5'b01000: begin
                e.mem_en     = 1'b1;
                e.mem_write  = w[5];  // store opcode
                e.mem_size   = f3;
                e.mem_addr   = a + (w[5] ? imm_s : imm_i);
                e.store_data = b;
            end
            default: e.trap = 1'b1;  // SYSTEM is the only other class issued
        endcase
        e.wb_en = (e.wb_rd != '0) &&
                  (w[6:2] inside {5'b01100, 5'b00100, 5'b01101, 5'b00101, 5'b11011, 5'b11001});
        if (e.wb_en) begin
            model_regs[e.wb_rd] = e.wb_data;
        end
    end
endtask

`endif

// ==== tb_tiny45_core.sv ====
// random testbench for tiny45_core; at most one strobe per cycle, each result checked in the cycle after
`timescale 1ns/1ps
`include "tiny45_consts.svh"

module tb_tiny45_core;

    localparam int RST_CYCLES = 3;
    localparam int IDLE_GAP   = 4;
    localparam int N_ALU      = 400;
    localparam int N_JUMP     = 120;
    localparam int N_BR       = 200;
    localparam int N_MEM      = 100;
    localparam int N_EXC      = 60;
    localparam int N_MIX      = 150;
    // mem and edge rounds issue two words and mix rounds may add an idle cycle
    localparam int CYCLE_LIMIT = RST_CYCLES + N_ALU + N_JUMP + N_BR + 2 * N_MEM + 2 * N_EXC +
                                 2 * N_MIX + 7 * IDLE_GAP + 50;

    logic                     clk;
    logic                     arst_n;
    logic                     instr_valid;
    logic [31:0]              instr;
    logic [31:0]              pc;
    logic                     result_valid;
    tiny45_pkg::exec_result_t result;

    integer                   seed;
    int                       errors;
    int                       checks;
    int                       strobes;
    int                       cycles;
    logic                     pend_valid;  // strobe issued last cycle
    tiny45_pkg::exec_result_t pend_res;
    logic [31:0]              last_word;

    `include "tiny45_core_model.svh"

    tiny45_core u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .pc           (pc),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_outputs();
        compare_field("result_valid", 32'(result_valid), 32'(pend_valid));
        if (pend_valid) begin
            compare_field("wb_en", 32'(result.wb_en), 32'(pend_res.wb_en));
            compare_field("next_pc", result.next_pc, pend_res.next_pc);
            compare_field("branch_taken", 32'(result.branch_taken), 32'(pend_res.branch_taken));
            compare_field("mem_en", 32'(result.mem_en), 32'(pend_res.mem_en));
            compare_field("mem_write", 32'(result.mem_write), 32'(pend_res.mem_write));
            compare_field("trap", 32'(result.trap), 32'(pend_res.trap));
            if (pend_res.wb_en) begin
                compare_field("wb_rd", 32'(result.wb_rd), 32'(pend_res.wb_rd));
                compare_field("wb_data", result.wb_data, pend_res.wb_data);
            end
            if (pend_res.mem_en) begin
                compare_field("mem_size", 32'(result.mem_size), 32'(pend_res.mem_size));
                compare_field("mem_addr", result.mem_addr, pend_res.mem_addr);
            end
            if (pend_res.mem_write) begin
                compare_field("store_data", result.store_data, pend_res.store_data);
            end
        end
    endtask

    // classes 0 alu reg, 1 alu imm, 2 lui, 3 auipc, 4 jal, 5 jalr, 6 branch,
    // 7 load, 8 store, 9 system, 10 16-bit word, 11 alu reg into x0
    function automatic logic [31:0] build_word(input int cls);
        logic [31:0] w;
        w = $random(seed);
        w[11] = 1'b0;  // keep register fields inside x0..x15
        w[19] = 1'b0;
        w[24] = 1'b0;
        case (cls)
            0, 11: begin
                w[6:0]   = 7'b0110011;
                w[31]    = 1'b0;
                w[29:25] = 5'b0;
            end
            1: w[6:0] = 7'b0010011;
            2: w[6:0] = 7'b0110111;
            3: w[6:0] = 7'b0010111;
            4: w[6:0] = 7'b1101111;
            5: begin
                w[6:0]   = 7'b1100111;
                w[14:12] = 3'b000;
            end
            6: begin
                w[6:0] = 7'b1100011;
                if (w[14:13] == 2'b01) begin
                    w[14] = 1'b1;  // funct3 2 and 3 are not branches
                end
                if (w[25]) begin
                    w[23:20] = w[18:15];  // equal operands half the time
                end
            end
            7: w[6:0] = 7'b0000011;
            8: w[6:0] = 7'b0100011;
            9: w[6:0] = 7'b1110011;
            default: begin
                if (w[1:0] == 2'b11) begin
                    w[1] = 1'b0;
                end
            end
        endcase
        if (cls == 11) begin
            w[11:7] = 5'b0;
        end
        return w;
    endfunction

    function automatic logic [31:0] rand_pc();
        logic [31:0] p;
        p = $random(seed);
        p[1:0] = 2'b00;
        return p;
    endfunction

    task automatic step(input logic v, input logic [31:0] w, input logic [31:0] p);
        tiny45_pkg::exec_result_t e;
        @(posedge clk);
        #2;
        check_outputs();
        instr_valid = v;
        instr       = w;
        pc          = p;
        pend_valid  = v;
        if (v) begin
            model_apply(w, p, e);
            pend_res = e;
            strobes++;
        end
    endtask

    // a writing word without a strobe must change nothing
    task automatic idle_cycles(input int n);
        repeat (n) step(1'b0, build_word(0), rand_pc());
    endtask

    task automatic random_run(input string name, input int n, input int lo, input int hi,
                              input logic follow, input logic sparse);
        int          err0;
        int          cls;
        logic [31:0] w;
        logic [31:0] reader;
        err0    = errors;
        strobes = 0;
        for (int i = 0; i < n; i++) begin
            if (sparse && ($random(seed) % 2 != 0)) begin
                idle_cycles(1);
            end
            cls = lo + $unsigned($random(seed)) % (hi - lo + 1);
            w = build_word(cls);
            if (cls <= 1 && i % 3 == 0) begin
                w[18:15] = last_word[10:7];  // depend on the previous rd
            end
            step(1'b1, w, rand_pc());
            if (follow) begin
                reader = build_word(0);
                reader[18:15] = w[10:7];  // register must hold its old value
                step(1'b1, reader, rand_pc());
            end
            last_word = w;
        end
        idle_cycles(IDLE_GAP);
        $display("%s done, %0d strobes, %0d errors", name, strobes, errors - err0);
    endtask

    initial begin
        seed        = 32'hca93_6ede;
        errors      = 0;
        checks      = 0;
        strobes     = 0;
        pend_valid  = 1'b0;
        pend_res    = '0;
        last_word   = '0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        for (int i = 0; i < `TINY45_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;
        compare_field("result_valid", 32'(result_valid), 32'd0);
        compare_field("wb_en", 32'(result.wb_en), 32'd0);
        compare_field("mem_en", 32'(result.mem_en), 32'd0);
        compare_field("trap", 32'(result.trap), 32'd0);
        idle_cycles(IDLE_GAP);
        $display("reset done, %0d errors", errors);
        random_run("alu_ops", N_ALU, 0, 1, 1'b0, 1'b0);
        random_run("jumps", N_JUMP, 2, 5, 1'b0, 1'b0);
        random_run("branches", N_BR, 6, 6, 1'b0, 1'b0);
        random_run("mem_ops", N_MEM, 7, 8, 1'b1, 1'b0);
        random_run("edge_words", N_EXC, 9, 11, 1'b1, 1'b0);
        random_run("idle_mix", N_MIX, 0, 11, 1'b0, 1'b1);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tiny45_alu.sv ====
// combinational 32-bit ALU; alu_op bit 3 selects sub or arithmetic shift, bits 2:0 follow funct3
`timescale 1ns/1ps

module tiny45_alu (
    input  logic [3:0]  alu_op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] y
);

    logic [4:0]  shamt;
    logic [31:0] sum;
    logic [31:0] diff;
    logic        lt_signed;
    logic        lt_unsigned;

    assign shamt = b[4:0];  // only the low five bits shift

    assign sum  = a + b;
    assign diff = a - b;

    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (alu_op[2:0])
            3'b000: begin
                y = alu_op[3] ? diff : sum;  // add / sub
            end
            3'b001: begin
                y = a << shamt;
            end
            3'b010: begin
                y = {31'b0, lt_signed};
            end
            3'b011: begin
                y = {31'b0, lt_unsigned};
            end
            3'b100: begin
                y = a ^ b;  // also the eq/ne compare
            end
            3'b101: begin
                if (alu_op[3]) begin
                    y = $unsigned($signed(a) >>> shamt);  // sra
                end else begin
                    y = a >> shamt;
                end
            end
            3'b110: begin
                y = a | b;
            end
            default: begin
                y = a & b;
            end
        endcase
    end

endmodule

// ==== tiny45_consts.svh ====
// register index width assumes RV32E; instr_len codes match the decoder's 2-bit length field
`ifndef TINY45_CONSTS_SVH
`define TINY45_CONSTS_SVH

// register file geometry
`define TINY45_REG_ADDR_BITS 4
`define TINY45_NUM_REGS      16

// instruction length codes
// bit 0 set means a 16-bit word and bit 1 set means a 32-bit word
`define TINY45_LEN_16 2'b01
`define TINY45_LEN_32 2'b10

// base increment of the PC for 32-bit words
`define TINY45_PC_STEP_32 32'd4
`define TINY45_PC_STEP_16 32'd2

`endif

// ==== tiny45_core.f ====
+incdir+.
tiny45_pkg.sv
tiny45_decoder.sv
tiny45_alu.sv
tiny45_regfile.sv
tiny45_exec_ctrl.sv
tiny45_core.sv
tb_tiny45_core.sv

// ==== tiny45_core.sv ====
// single-issue execute slice with 1-cycle latency; no fetch, no data memory, no CSRs
`timescale 1ns/1ps
`include "tiny45_consts.svh"

module tiny45_core (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     instr_valid,
    input  logic [31:0]              instr,
    input  logic [31:0]              pc,
    output logic                     result_valid,
    output tiny45_pkg::exec_result_t result
);

    tiny45_pkg::decoded_t             dec;
    logic [31:0]                      rs1_data;
    logic [31:0]                      rs2_data;
    logic [31:0]                      alu_a;
    logic [31:0]                      alu_b;
    logic [31:0]                      alu_result;
    logic                             rf_we;
    logic [`TINY45_REG_ADDR_BITS-1:0] rf_waddr;
    logic [31:0]                      rf_wdata;

    tiny45_decoder #(
        .REG_ADDR_BITS(`TINY45_REG_ADDR_BITS)
    ) u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    tiny45_regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    tiny45_alu u_alu (
        .alu_op (dec.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .y      (alu_result)
    );

    tiny45_exec_ctrl u_exec_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .pc           (pc),
        .dec          (dec),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_result   (alu_result),
        .we           (rf_we),
        .waddr        (rf_waddr),
        .wdata        (rf_wdata),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// ==== tiny45_decoder.sv ====
// purely combinational; class flags decode opcode bits 6:2 even for 16-bit words, so callers gate on instr_len
`timescale 1ns/1ps
`include "tiny45_consts.svh"

module tiny45_decoder #(
    parameter int REG_ADDR_BITS = `TINY45_REG_ADDR_BITS
) (
    input  logic [31:0]          instr,
    output tiny45_pkg::decoded_t dec
);

    tiny45_pkg::instr_view_u iv;
    logic [4:0]              op;
    logic [31:0]             imm_i;
    logic [31:0]             imm_s;
    logic [31:0]             imm_b;
    logic [31:0]             imm_u;
    logic [31:0]             imm_j;

    assign iv = instr;
    assign op = iv.r_view.opcode[6:2];

    // immediates built from the R/S view
    assign imm_i = {{21{iv.r_view.funct7[6]}}, iv.r_view.funct7[5:0], iv.r_view.rs2};
    assign imm_s = {{21{iv.r_view.funct7[6]}}, iv.r_view.funct7[5:0], iv.r_view.rd};
    assign imm_b = {{20{iv.r_view.funct7[6]}}, iv.r_view.rd[0], iv.r_view.funct7[5:0],
                    iv.r_view.rd[4:1], 1'b0};

    // upper and jump immediates come from the U/J view
    assign imm_u = {iv.u_view.imm_hi, 12'b0};
    assign imm_j = {{12{iv.u_view.imm_hi[19]}}, iv.u_view.imm_hi[7:0], iv.u_view.imm_hi[8],
                    iv.u_view.imm_hi[18:9], 1'b0};

    always_comb begin
        dec.is_load    = (op == 5'b00000);  // rd <- mem[rs1+I]
        dec.is_alu_imm = (op == 5'b00100);  // rd <- rs1 op I
        dec.is_auipc   = (op == 5'b00101);  // rd <- pc + U
        dec.is_store   = (op == 5'b01000);  // mem[rs1+S] <- rs2
        dec.is_alu_reg = (op == 5'b01100);  // rd <- rs1 op rs2
        dec.is_lui     = (op == 5'b01101);  // rd <- U
        dec.is_branch  = (op == 5'b11000);  // pc <- pc + B if taken
        dec.is_jalr    = (op == 5'b11001);  // rd <- pc+4, pc <- rs1+I
        dec.is_jal     = (op == 5'b11011);  // rd <- pc+4, pc <- pc+J
        dec.is_system  = (op == 5'b11100);  // traps only

        if (dec.is_auipc || dec.is_lui) begin
            dec.imm = imm_u;
        end else if (dec.is_store) begin
            dec.imm = imm_s;
        end else if (dec.is_branch) begin
            dec.imm = imm_b;
        end else if (dec.is_jal) begin
            dec.imm = imm_j;
        end else begin
            dec.imm = imm_i;
        end

        dec.instr_len = (iv.r_view.opcode[1:0] == 2'b11) ? `TINY45_LEN_32 : `TINY45_LEN_16;

        // address-forming classes all add
        if (dec.is_load || dec.is_auipc || dec.is_store || dec.is_jalr || dec.is_jal) begin
            dec.alu_op = 4'b0000;
        end else if (dec.is_branch) begin
            // xor for eq/ne, slt or sltu for the ordered compares
            dec.alu_op = {1'b0, ~iv.r_view.funct3[2], iv.r_view.funct3[2:1]};
        end else begin
            // funct7 bit 5 only matters for sub and the right shifts
            dec.alu_op = {iv.r_view.funct7[5] &&
                          (iv.r_view.opcode[5] || iv.r_view.funct3[1:0] == 2'b01),
                          iv.r_view.funct3};
        end

        dec.mem_op = iv.r_view.funct3;

        dec.rs1 = tiny45_pkg::reg_addr_t'(iv.r_view.rs1[REG_ADDR_BITS-1:0]);
        dec.rs2 = tiny45_pkg::reg_addr_t'(iv.r_view.rs2[REG_ADDR_BITS-1:0]);
        dec.rd  = tiny45_pkg::reg_addr_t'(iv.r_view.rd[REG_ADDR_BITS-1:0]);
    end

endmodule

// ==== tiny45_exec_ctrl.sv ====
// no back-pressure; result is valid only in the cycle after a strobe, and loads never write rd
`timescale 1ns/1ps
`include "tiny45_consts.svh"

module tiny45_exec_ctrl (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             instr_valid,
    input  logic [31:0]                      pc,
    input  tiny45_pkg::decoded_t             dec,
    input  logic [31:0]                      rs1_data,
    input  logic [31:0]                      rs2_data,
    output logic [31:0]                      alu_a,
    output logic [31:0]                      alu_b,
    input  logic [31:0]                      alu_result,
    output logic                             we,
    output logic [`TINY45_REG_ADDR_BITS-1:0] waddr,
    output logic [31:0]                      wdata,
    output logic                             result_valid,
    output tiny45_pkg::exec_result_t         result
);

    tiny45_pkg::exec_result_t res_nxt;
    logic                     is_32;
    logic                     cond;
    logic                     taken;
    logic                     writes_rd;
    logic [31:0]              pc_plus_len;
    logic [31:0]              pc_plus_4;
    logic [31:0]              pc_plus_imm;
    logic [31:0]              rs1_plus_imm;

    // compressed words only move the pc
    assign is_32 = (dec.instr_len == `TINY45_LEN_32);

    assign alu_a = (dec.is_auipc || dec.is_jal) ? pc : rs1_data;
    assign alu_b = (dec.is_alu_reg || dec.is_branch) ? rs2_data : dec.imm;

    assign pc_plus_4    = pc + `TINY45_PC_STEP_32;
    assign pc_plus_len  = is_32 ? pc_plus_4 : pc + `TINY45_PC_STEP_16;
    assign pc_plus_imm  = pc + dec.imm;
    assign rs1_plus_imm = rs1_data + dec.imm;  // load/store address and jalr target

    // xor gives zero on equal, slt/sltu give one on less
    assign cond  = dec.alu_op[2] ? (alu_result == '0) : (alu_result != '0);
    assign taken = is_32 && dec.is_branch && (cond ^ dec.mem_op[0]);

    assign writes_rd = dec.is_alu_reg || dec.is_alu_imm || dec.is_lui ||
                       dec.is_auipc || dec.is_jal || dec.is_jalr;

    always_comb begin
        res_nxt.wb_en = is_32 && writes_rd && (dec.rd != '0);
        res_nxt.wb_rd = dec.rd;

        if (dec.is_lui) begin
            res_nxt.wb_data = dec.imm;
        end else if (dec.is_jal || dec.is_jalr) begin
            res_nxt.wb_data = pc_plus_4;  // link
        end else begin
            res_nxt.wb_data = alu_result;  // alu ops and auipc
        end

        if (is_32 && (dec.is_jal || taken)) begin
            res_nxt.next_pc = pc_plus_imm;
        end else if (is_32 && dec.is_jalr) begin
            res_nxt.next_pc = {rs1_plus_imm[31:1], 1'b0};
        end else begin
            res_nxt.next_pc = pc_plus_len;
        end

        res_nxt.branch_taken = taken;
        res_nxt.mem_en       = is_32 && (dec.is_load || dec.is_store);
        res_nxt.mem_write    = is_32 && dec.is_store;
        res_nxt.mem_size     = dec.mem_op;
        res_nxt.mem_addr     = rs1_plus_imm;
        res_nxt.store_data   = rs2_data;
        res_nxt.trap         = is_32 && dec.is_system;
    end

    // regfile write commits at the same edge as the result register
    assign we    = instr_valid && res_nxt.wb_en;
    assign waddr = res_nxt.wb_rd;
    assign wdata = res_nxt.wb_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            result_valid <= instr_valid;  // one-cycle pulse per strobe
            if (instr_valid) begin
                result <= res_nxt;
            end
        end
    end

endmodule

// ==== tiny45_pkg.sv ====
// types only; register index width comes from tiny45_consts.svh and must stay 4 for RV32E
`include "tiny45_consts.svh"

package tiny45_pkg;

    typedef logic [`TINY45_REG_ADDR_BITS-1:0] reg_addr_t;

    // R/S style field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // U/J style field layout
    typedef struct packed {
        logic [19:0] imm_hi;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_view_t;

    typedef union packed {
        r_view_t r_view;
        u_view_t u_view;
    } instr_view_u;

    typedef struct packed {
        logic        is_load;
        logic        is_alu_imm;
        logic        is_auipc;
        logic        is_store;
        logic        is_alu_reg;
        logic        is_lui;
        logic        is_branch;
        logic        is_jalr;
        logic        is_jal;
        logic        is_system;
        logic [31:0] imm;
        logic [1:0]  instr_len;
        logic [3:0]  alu_op;     // bit 3 sub/sra, bits 2:0 funct3
        logic [2:0]  mem_op;     // bit 0 inverts the branch test
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
    } decoded_t;

    typedef struct packed {
        logic        wb_en;
        reg_addr_t   wb_rd;
        logic [31:0] wb_data;
        logic [31:0] next_pc;
        logic        branch_taken;
        logic        mem_en;
        logic        mem_write;
        logic [2:0]  mem_size;
        logic [31:0] mem_addr;
        logic [31:0] store_data;
        logic        trap;
    } exec_result_t;

endpackage

// ==== tiny45_regfile.sv ====
// 16 x 32 registers cleared on reset; x0 always reads zero and reads see only completed writes
`timescale 1ns/1ps
`include "tiny45_consts.svh"

module tiny45_regfile (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [`TINY45_REG_ADDR_BITS-1:0] raddr1,
    input  logic [`TINY45_REG_ADDR_BITS-1:0] raddr2,
    output logic [31:0]                      rdata1,
    output logic [31:0]                      rdata2,
    input  logic                             we,
    input  logic [`TINY45_REG_ADDR_BITS-1:0] waddr,
    input  logic [31:0]                      wdata
);

    logic [31:0] regs [`TINY45_NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `TINY45_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin  // x0 never stored
            regs[waddr] <= wdata;
        end
    end

    // combinational reads with no write bypass
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end

        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule
